// File: build.f
logic/mips_pkg.sv
logic/regfile.sv
logic/alu.sv
logic/decoder.sv
logic/axil_master.sv
logic/core_datapath.sv
logic/mips_top.sv
bench/axil_mem.sv
bench/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it; exit status reflects the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_top -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST OK" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: bench/tb_top.sv
// testbench for mips_top; runs a random program and compares bus traffic with a reference model
`timescale 1ns/1ps

module tb_top;
  import mips_pkg::*;

  localparam word_t RV = DEFAULT_RESET_VECTOR;

  logic clk, reset;
  logic [7:0] delay_rnd;
  word_t araddr, rdata, awaddr, wdata, reg_v0, wr_addr, wr_data;
  logic [1:0] rresp, bresp;
  logic [3:0] wstrb;
  logic arvalid, arready, rvalid, rready, awvalid, awready;
  logic wvalid, wready, bvalid, bready, halted, wr_valid;

  word_t lcg_state;
  word_t regs [32];
  word_t dmem [64];
  word_t prog [64];
  word_t exp_fetch [$];
  word_t exp_st_addr [$];
  word_t exp_st_data [$];
  int errors;
  logic first_fetch;

  mips_top #(.RESET_VECTOR(RV)) uut (
    .clk(clk), .reset(reset),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .reg_v0(reg_v0), .halted(halted)
  );

  axil_mem mem (
    .clk(clk), .reset(reset), .rnd(delay_rnd),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_data(wr_data)
  );

  function automatic word_t next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 8;
  endfunction

  task automatic check_word(string name, word_t exp, word_t act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected %b got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_strobe(string name, logic [3:0] exp, logic [3:0] act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // random program of register ops, loads, stores and forward control flow
  task automatic build_program();
    word_t r, tgt;
    logic [4:0] rs, rt, rd;
    logic [5:0] fn;
    for (int i = 0; i < 59; i++) begin
      r  = next_rand();
      rs = 5'(r[2:0] % 8);
      rt = 5'(1 + r[5:3] % 7);
      rd = 5'(1 + r[8:6] % 7);
      fn = (r[11:10] == 0) ? 6'h24 : (r[11:10] == 1) ? 6'h25 : 6'h2A;
      case (next_rand() % 10)
        0: prog[i] = {6'h00, rs, rt, rd, 5'd0, 6'h21};
        1: prog[i] = {6'h00, rs, rt, rd, 5'd0, 6'h23};
        2: prog[i] = {6'h00, rs, rt, rd, 5'd0, fn};
        3: prog[i] = {6'h00, 5'd0, rt, rd, r[16:12], 6'h00};
        4: prog[i] = {6'h09, rs, rt, r[23:8]};
        5: prog[i] = {6'h0F, 5'd0, rt, r[23:8]};
        6: prog[i] = {6'h23, 5'd0, rt, 8'd0, r[17:12], 2'b00};
        7: prog[i] = {6'h2B, 5'd0, rt, 8'd0, r[17:12], 2'b00};
        8: prog[i] = {6'h04, rs, rt, 16'(r[23:12] % (59 - i))};
        default: begin
          tgt     = RV + 4 * (i + 1 + int'(r[23:12] % (59 - i)));
          prog[i] = {6'h02, tgt[27:2]};
        end
      endcase
    end
    prog[59] = 32'h0000_000D;
    for (int i = 60; i < 64; i++) prog[i] = 32'h0000_000D;
  endtask

  // reference interpreter; records fetches, stores and final registers
  task automatic run_model();
    word_t pc, ins, simm, ea;
    int steps;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    pc = RV;
    steps = 0;
    while (steps < 200) begin
      exp_fetch.push_back(pc);
      ins  = prog[pc[7:2]];
      simm = {{16{ins[15]}}, ins[15:0]};
      ea   = regs[ins[25:21]] + simm;
      pc   = pc + 4;
      steps++;
      case (ins[31:26])
        6'h00: begin
          case (ins[5:0])
            6'h21: regs[ins[15:11]] = regs[ins[25:21]] + regs[ins[20:16]];
            6'h23: regs[ins[15:11]] = regs[ins[25:21]] - regs[ins[20:16]];
            6'h24: regs[ins[15:11]] = regs[ins[25:21]] & regs[ins[20:16]];
            6'h25: regs[ins[15:11]] = regs[ins[25:21]] | regs[ins[20:16]];
            6'h2A: regs[ins[15:11]] =
                ($signed(regs[ins[25:21]]) < $signed(regs[ins[20:16]])) ? 1 : 0;
            6'h00: regs[ins[15:11]] = regs[ins[20:16]] << ins[10:6];
            default: break;
          endcase
        end
        6'h09: regs[ins[20:16]] = regs[ins[25:21]] + simm;
        6'h0F: regs[ins[20:16]] = {ins[15:0], 16'h0000};
        6'h23: regs[ins[20:16]] = dmem[ea[7:2]];
        6'h2B: begin
          dmem[ea[7:2]] = regs[ins[20:16]];
          exp_st_addr.push_back(ea);
          exp_st_data.push_back(regs[ins[20:16]]);
        end
        6'h04: if (regs[ins[25:21]] == regs[ins[20:16]]) pc = pc + (simm << 2);
        6'h02: pc = {pc[31:28], ins[25:0], 2'b00};
        default: break;
      endcase
      regs[0] = '0;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin : ready_delays
    word_t r;
    r = next_rand();
    delay_rnd <= r[7:0];
  end

  // bus monitor: fetch order, store contents and write strobes against the model
  always @(posedge clk) begin
    if (!reset && arvalid && arready && araddr[31:20] == 12'hBFC) begin
      if (first_fetch) check_word("first araddr", RV, araddr);
      first_fetch <= 1'b0;
      if (exp_fetch.size() == 0) begin
        $display("fetch at %h beyond the model's program flow", araddr);
        errors++;
      end else begin
        check_word("fetch araddr", exp_fetch.pop_front(), araddr);
      end
    end
    if (!reset && wvalid && wready) begin
      check_strobe("wstrb", 4'hF, wstrb);
    end
    if (!reset && wr_valid) begin
      if (exp_st_addr.size() == 0) begin
        $display("unexpected store to %h", wr_addr);
        errors++;
      end else begin
        check_word("store awaddr", exp_st_addr.pop_front(), wr_addr);
        check_word("store wdata", exp_st_data.pop_front(), wr_data);
      end
    end
  end

  initial begin : main
    int cycles;
    core_state_e st;
    reset = 1'b1;
    delay_rnd = '0;
    errors = 0;
    first_fetch = 1'b1;
    lcg_state = 32'd57;
    build_program();
    for (int i = 0; i < 64; i++) begin
      dmem[i] = next_rand() ^ (32'h1000 * i);
      mem.data[i] = dmem[i];
      mem.prog[i] = prog[i];
    end
    run_model();
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_flag("halted", 1'b0, halted);
    check_flag("arvalid", 1'b0, arvalid);
    check_flag("awvalid", 1'b0, awvalid);
    check_flag("wvalid", 1'b0, wvalid);
    check_flag("rready", 1'b1, rready);
    check_flag("bready", 1'b1, bready);
    cycles = 0;
    while (!halted && cycles < 20000) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      st = uut.u_core.state;
      $display("timeout waiting for halt, core in state %s", st.name());
      $display("errors: %0d", errors);
      $display("TEST FAILED");
      $finish;
    end else begin
      check_word("reg_v0", regs[2], reg_v0);
      cycles = 0;
      while (cycles < 50) begin
        @(negedge clk);
        check_flag("halted", 1'b1, halted);
        if (arvalid || awvalid || wvalid) begin
          $display("bus request issued after halt at t=%0t", $time);
          errors++;
        end
        cycles++;
      end
      if (exp_fetch.size() != 0 || exp_st_addr.size() != 0) begin
        $display("core halted with %0d fetches and %0d stores still expected",
                 exp_fetch.size(), exp_st_addr.size());
        errors++;
      end
      $display("errors: %0d", errors);
      if (errors == 0) begin
        $display("TEST OK");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule

// File: bench/axil_mem.sv
// AXI4-Lite slave memory for the testbench; serves program and data words and reports each write
`timescale 1ns/1ps

module axil_mem (
  input  logic            clk,
  input  logic            reset,
  input  logic [7:0]      rnd,
  input  mips_pkg::word_t araddr,
  input  logic            arvalid,
  output logic            arready,
  output mips_pkg::word_t rdata,
  output logic [1:0]      rresp,
  output logic            rvalid,
  input  logic            rready,
  input  mips_pkg::word_t awaddr,
  input  logic            awvalid,
  output logic            awready,
  input  mips_pkg::word_t wdata,
  input  logic            wvalid,
  output logic            wready,
  output logic [1:0]      bresp,
  output logic            bvalid,
  input  logic            bready,
  output logic            wr_valid,
  output mips_pkg::word_t wr_addr,
  output mips_pkg::word_t wr_data
);
  import mips_pkg::*;

  // program region sits at the reset vector, data region at address zero
  word_t prog [64];
  word_t data [64];

  logic [1:0] rcnt, awcnt, wcnt, bcnt;
  logic       r_pend, aw_got, w_got;
  word_t      raddr_q, waddr_q, wdata_q;

  assign rresp   = 2'b00;
  assign bresp   = 2'b00;
  assign wr_addr = waddr_q;
  assign wr_data = wdata_q;

  function automatic word_t read_word(word_t addr);
    if (addr[31:20] == 12'hBFC) begin
      return prog[addr[7:2]];
    end
    return data[addr[7:2]];
  endfunction

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      arready  <= 1'b0;
      rvalid   <= 1'b0;
      rdata    <= '0;
      r_pend   <= 1'b0;
      rcnt     <= '0;
      raddr_q  <= '0;
      awready  <= 1'b0;
      wready   <= 1'b0;
      bvalid   <= 1'b0;
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
      awcnt    <= '0;
      wcnt     <= '0;
      bcnt     <= '0;
      waddr_q  <= '0;
      wdata_q  <= '0;
      wr_valid <= 1'b0;
    end else begin
      wr_valid <= 1'b0;
      // read address, then read data after a random delay
      if (arvalid && arready) begin
        arready <= 1'b0;
        r_pend  <= 1'b1;
        raddr_q <= araddr;
        rcnt    <= rnd[1:0];
      end else if (arvalid && !r_pend) begin
        if (rcnt == 0) arready <= 1'b1;
        else rcnt <= rcnt - 1'b1;
      end
      if (r_pend && !rvalid) begin
        if (rcnt == 0) begin
          rvalid <= 1'b1;
          rdata  <= read_word(raddr_q);
        end else begin
          rcnt <= rcnt - 1'b1;
        end
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
        r_pend <= 1'b0;
        rcnt   <= rnd[1:0];
      end
      // write address and data are taken independently
      if (awvalid && awready) begin
        awready <= 1'b0;
        aw_got  <= 1'b1;
        waddr_q <= awaddr;
        awcnt   <= rnd[3:2];
      end else if (awvalid && !aw_got) begin
        if (awcnt == 0) awready <= 1'b1;
        else awcnt <= awcnt - 1'b1;
      end
      if (wvalid && wready) begin
        wready  <= 1'b0;
        w_got   <= 1'b1;
        wdata_q <= wdata;
        wcnt    <= rnd[5:4];
      end else if (wvalid && !w_got) begin
        if (wcnt == 0) wready <= 1'b1;
        else wcnt <= wcnt - 1'b1;
      end
      if (aw_got && w_got && !bvalid) begin
        if (bcnt == 0) begin
          bvalid   <= 1'b1;
          wr_valid <= 1'b1;
        end else begin
          bcnt <= bcnt - 1'b1;
        end
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        bcnt   <= rnd[7:6];
      end
    end
  end

  // stores land in the data region when the response is raised
  always @(posedge clk) begin
    if (!reset && aw_got && w_got && !bvalid && bcnt == 0) begin
      data[waddr_q[7:2]] <= wdata_q;
    end
  end

endmodule

// File: logic/mips_top.sv
// top level of the multicycle MIPS core with its AXI4-Lite master port
`timescale 1ns/1ps

module mips_top #(
  parameter mips_pkg::word_t RESET_VECTOR = mips_pkg::DEFAULT_RESET_VECTOR
) (
  input  logic            clk,
  input  logic            reset,
  output mips_pkg::word_t araddr,
  output logic            arvalid,
  input  logic            arready,
  input  mips_pkg::word_t rdata,
  input  logic [1:0]      rresp,
  input  logic            rvalid,
  output logic            rready,
  output mips_pkg::word_t awaddr,
  output logic            awvalid,
  input  logic            awready,
  output mips_pkg::word_t wdata,
  output logic [3:0]      wstrb,
  output logic            wvalid,
  input  logic            wready,
  input  logic [1:0]      bresp,
  input  logic            bvalid,
  output logic            bready,
  output mips_pkg::word_t reg_v0,
  output logic            halted
);
  import mips_pkg::*;

  bus_req_t  req;
  logic      req_valid;
  logic      done;
  word_t     bus_rdata;
  word_t     instr;
  word_t     pc_plus4;
  ctrl_t     ctrl;
  word_t     imm;
  word_t     branch_target;
  word_t     jump_target;
  alu_op_e   alu_op;
  word_t     alu_a;
  word_t     alu_b;
  logic [4:0] shamt;
  word_t     alu_result;
  logic      alu_zero;
  reg_idx_t  ra1;
  reg_idx_t  ra2;
  reg_idx_t  wa;
  logic      we;
  word_t     wd;
  word_t     rd1;
  word_t     rd2;

  core_datapath #(
    .RESET_VECTOR(RESET_VECTOR)
  ) u_core (
    .clk(clk), .reset(reset),
    .req(req), .req_valid(req_valid), .done(done), .rdata(bus_rdata),
    .instr(instr), .pc_plus4(pc_plus4), .ctrl(ctrl), .imm(imm),
    .branch_target(branch_target), .jump_target(jump_target),
    .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .shamt(shamt),
    .alu_result(alu_result), .alu_zero(alu_zero),
    .ra1(ra1), .ra2(ra2), .wa(wa), .we(we), .wd(wd), .rd1(rd1), .rd2(rd2),
    .halted(halted)
  );

  decoder u_dec (
    .instr(instr), .pc_plus4(pc_plus4), .ctrl(ctrl), .imm(imm),
    .branch_target(branch_target), .jump_target(jump_target)
  );

  alu u_alu (
    .op(alu_op), .a(alu_a), .b(alu_b), .shamt(shamt),
    .result(alu_result), .zero(alu_zero)
  );

  regfile u_rf (
    .clk(clk), .reset(reset), .we(we), .ra1(ra1), .ra2(ra2), .wa(wa),
    .wd(wd), .rd1(rd1), .rd2(rd2), .reg_v0(reg_v0)
  );

  axil_master u_bus (
    .clk(clk), .reset(reset),
    .req(req), .req_valid(req_valid), .done(done), .read_data(bus_rdata),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready)
  );

endmodule

// File: logic/core_datapath.sv
// multicycle sequencer and datapath registers of the core; drives decoder, ALU, regfile and bus
`timescale 1ns/1ps

module core_datapath #(
  parameter mips_pkg::word_t RESET_VECTOR = mips_pkg::DEFAULT_RESET_VECTOR
) (
  input  logic                clk,
  input  logic                reset,
  output mips_pkg::bus_req_t  req,
  output logic                req_valid,
  input  logic                done,
  input  mips_pkg::word_t     rdata,
  output mips_pkg::word_t     instr,
  output mips_pkg::word_t     pc_plus4,
  input  mips_pkg::ctrl_t     ctrl,
  input  mips_pkg::word_t     imm,
  input  mips_pkg::word_t     branch_target,
  input  mips_pkg::word_t     jump_target,
  output mips_pkg::alu_op_e   alu_op,
  output mips_pkg::word_t     alu_a,
  output mips_pkg::word_t     alu_b,
  output logic [4:0]          shamt,
  input  mips_pkg::word_t     alu_result,
  input  logic                alu_zero,
  output mips_pkg::reg_idx_t  ra1,
  output mips_pkg::reg_idx_t  ra2,
  output mips_pkg::reg_idx_t  wa,
  output logic                we,
  output mips_pkg::word_t     wd,
  input  mips_pkg::word_t     rd1,
  input  mips_pkg::word_t     rd2,
  output logic                halted
);
  import mips_pkg::*;

  core_state_e state;
  word_t       pc;
  // a bus request is outstanding
  logic        busy;

  word_t ir;
  word_t a_q;
  word_t b_q;
  word_t alu_q;
  word_t mdr;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= ST_FETCH;
      pc    <= RESET_VECTOR;
      busy  <= 1'b0;
    end else begin
      if (req_valid) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
      case (state)
        ST_FETCH: begin
          if (done) state <= ST_DECODE;
        end
        ST_DECODE: begin
          // break and unknown opcodes both stop the core
          state <= (ctrl.halt || ctrl.illegal) ? ST_HALTED : ST_EXECUTE;
        end
        ST_EXECUTE: begin
          if (ctrl.jump) begin
            pc <= jump_target;
          end else if (ctrl.branch && alu_zero) begin
            pc <= branch_target;
          end else begin
            pc <= pc_plus4;
          end
          state <= (ctrl.mem_read || ctrl.mem_write) ? ST_MEMORY : ST_WRITEBACK;
        end
        ST_MEMORY: begin
          if (done) state <= ST_WRITEBACK;
        end
        ST_WRITEBACK: begin
          state <= ST_FETCH;
        end
        default: begin
          state <= ST_HALTED;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_FETCH && done) ir <= rdata;
    if (state == ST_DECODE) begin
      a_q <= rd1;
      b_q <= rd2;
    end
    if (state == ST_EXECUTE) alu_q <= alu_result;
    if (state == ST_MEMORY && done) mdr <= rdata;
  end

  assign instr    = ir;
  assign pc_plus4 = pc + 32'd4;

  // rs and rt fields
  assign ra1 = ir[25:21];
  assign ra2 = ir[20:16];

  assign alu_op = ctrl.alu_op;
  assign alu_a  = a_q;
  assign alu_b  = ctrl.alu_src_imm ? imm : b_q;
  assign shamt  = ir[10:6];

  // one request per fetch or memory state, held off until done
  assign req_valid = (state == ST_FETCH || state == ST_MEMORY) && !busy;

  always_comb begin
    req.write = (state == ST_MEMORY) && ctrl.mem_write;
    req.addr  = (state == ST_MEMORY) ? alu_q : pc;
    req.wdata = b_q;
  end

  assign we     = (state == ST_WRITEBACK) && ctrl.reg_write;
  assign wa     = ctrl.dst_rt ? ir[20:16] : ir[15:11];
  assign wd     = ctrl.mem_read ? mdr : alu_q;
  assign halted = (state == ST_HALTED);

endmodule

// File: logic/axil_master.sv
// AXI4-Lite master; runs one core bus request at a time and pulses done at the end
`timescale 1ns/1ps

module axil_master (
  input  logic                clk,
  input  logic                reset,
  input  mips_pkg::bus_req_t  req,
  input  logic                req_valid,
  output logic                done,
  output mips_pkg::word_t     read_data,
  output mips_pkg::word_t     araddr,
  output logic                arvalid,
  input  logic                arready,
  input  mips_pkg::word_t     rdata,
  input  logic [1:0]          rresp,
  input  logic                rvalid,
  output logic                rready,
  output mips_pkg::word_t     awaddr,
  output logic                awvalid,
  input  logic                awready,
  output mips_pkg::word_t     wdata,
  output logic [3:0]          wstrb,
  output logic                wvalid,
  input  logic                wready,
  input  logic [1:0]          bresp,
  input  logic                bvalid,
  output logic                bready
);
  import mips_pkg::*;

  typedef enum logic [1:0] {
    M_IDLE,
    M_ADDR,
    M_DATA,
    M_RESP
  } bus_state_e;

  bus_state_e state;
  logic       is_write;
  word_t      addr_q;
  word_t      data_q;

  assign araddr = addr_q;
  assign awaddr = addr_q;
  assign wdata  = data_q;
  assign wstrb  = 4'hF;
  // responses are always taken, resp codes are not looked at
  assign rready = 1'b1;
  assign bready = 1'b1;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= M_IDLE;
      is_write <= 1'b0;
      arvalid  <= 1'b0;
      awvalid  <= 1'b0;
      wvalid   <= 1'b0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        M_IDLE: begin
          if (req_valid) begin
            is_write <= req.write;
            arvalid  <= !req.write;
            awvalid  <= req.write;
            wvalid   <= req.write;
            state    <= M_ADDR;
          end
        end
        M_ADDR: begin
          if (is_write) begin
            // address and data channels complete on their own
            if (awready) awvalid <= 1'b0;
            if (wready) wvalid <= 1'b0;
            if ((awready || !awvalid) && (wready || !wvalid)) state <= M_RESP;
          end else if (arready) begin
            arvalid <= 1'b0;
            state   <= M_DATA;
          end
        end
        M_DATA: begin
          if (rvalid) begin
            done  <= 1'b1;
            state <= M_IDLE;
          end
        end
        default: begin
          if (bvalid) begin
            done  <= 1'b1;
            state <= M_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == M_IDLE && req_valid) begin
      addr_q <= req.addr;
      data_q <= req.wdata;
    end
    if (state == M_DATA && rvalid) read_data <= rdata;
  end

endmodule

// File: logic/decoder.sv
// instruction decoder; turns the instruction register into controls, immediate and targets
`timescale 1ns/1ps

module decoder (
  input  mips_pkg::word_t instr,
  input  mips_pkg::word_t pc_plus4,
  output mips_pkg::ctrl_t ctrl,
  output mips_pkg::word_t imm,
  output mips_pkg::word_t branch_target,
  output mips_pkg::word_t jump_target
);
  import mips_pkg::*;

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = ALU_ADD;
    case (opcode)
      OP_RTYPE: begin
        ctrl.reg_write = 1'b1;
        case (funct)
          FN_SLL:  ctrl.alu_op = ALU_SLL;
          FN_ADDU: ctrl.alu_op = ALU_ADD;
          FN_SUBU: ctrl.alu_op = ALU_SUB;
          FN_AND:  ctrl.alu_op = ALU_AND;
          FN_OR:   ctrl.alu_op = ALU_OR;
          FN_SLT:  ctrl.alu_op = ALU_SLT;
          FN_BREAK: begin
            ctrl.reg_write = 1'b0;
            ctrl.halt      = 1'b1;
          end
          default: begin
            ctrl.reg_write = 1'b0;
            ctrl.illegal   = 1'b1;
          end
        endcase
      end
      OP_ADDIU: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.dst_rt      = 1'b1;
      end
      OP_LUI: begin
        ctrl.alu_op      = ALU_LUI;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.dst_rt      = 1'b1;
      end
      OP_LW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.dst_rt      = 1'b1;
        ctrl.mem_read    = 1'b1;
      end
      OP_SW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      OP_BEQ: begin
        // rs - rt, taken on zero
        ctrl.alu_op = ALU_SUB;
        ctrl.branch = 1'b1;
      end
      OP_J: begin
        ctrl.jump = 1'b1;
      end
      default: begin
        ctrl.illegal = 1'b1;
      end
    endcase
  end

  assign imm           = {{16{instr[15]}}, instr[15:0]};
  assign branch_target = pc_plus4 + {imm[29:0], 2'b00};
  // j stays inside the current 256 MB region
  assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00};

endmodule

// File: logic/alu.sv
// combinational ALU of the core; zero flag serves beq compares
`timescale 1ns/1ps

module alu (
  input  mips_pkg::alu_op_e op,
  input  mips_pkg::word_t   a,
  input  mips_pkg::word_t   b,
  input  logic [4:0]        shamt,
  output mips_pkg::word_t   result,
  output logic              zero
);
  import mips_pkg::*;

  always_comb begin
    case (op)
      ALU_ADD: begin
        result = a + b;
      end
      ALU_SUB: begin
        result = a - b;
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_OR: begin
        result = a | b;
      end
      ALU_SLT: begin
        // signed compare
        result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      end
      ALU_SLL: begin
        // sll shifts rt, which comes in on b
        result = b << shamt;
      end
      ALU_LUI: begin
        result = {b[15:0], 16'h0000};
      end
      default: begin
        result = '0;
      end
    endcase
  end

  assign zero = (result == '0);

endmodule

// File: logic/regfile.sv
// 32x32 register file with two combinational reads and one clocked write, used by the core
`timescale 1ns/1ps

module regfile (
  input  logic              clk,
  input  logic              reset,
  input  logic              we,
  input  mips_pkg::reg_idx_t ra1,
  input  mips_pkg::reg_idx_t ra2,
  input  mips_pkg::reg_idx_t wa,
  input  mips_pkg::word_t   wd,
  output mips_pkg::word_t   rd1,
  output mips_pkg::word_t   rd2,
  output mips_pkg::word_t   reg_v0
);
  import mips_pkg::*;

  word_t rf [32];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        rf[i] <= '0;
      end
    end else if (we && wa != '0) begin
      rf[wa] <= wd;
    end
  end

  // $zero never holds anything but zero
  assign rd1 = (ra1 == '0) ? '0 : rf[ra1];
  assign rd2 = (ra2 == '0) ? '0 : rf[ra2];

  // $v0 tap for observing results
  assign reg_v0 = rf[2];

endmodule

// File: logic/mips_pkg.sv
// shared types, encodings and constants for the multicycle MIPS core; import into each module
package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // first fetch address unless the top level overrides it
  localparam word_t DEFAULT_RESET_VECTOR = 32'hBFC0_0000;

  // primary opcode field, instr[31:26]
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_ADDIU = 6'h09,
    OP_LUI   = 6'h0F,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2B
  } opcode_e;

  // funct field for R-type, instr[5:0]
  typedef enum logic [5:0] {
    FN_SLL   = 6'h00,
    FN_BREAK = 6'h0D,
    FN_ADDU  = 6'h21,
    FN_SUBU  = 6'h23,
    FN_AND   = 6'h24,
    FN_OR    = 6'h25,
    FN_SLT   = 6'h2A
  } funct_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_SLL,
    ALU_LUI
  } alu_op_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src_imm;
    logic    reg_write;
    logic    dst_rt;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    logic    jump;
    logic    halt;
    logic    illegal;
  } ctrl_t;

  // one word-wide access, read or write
  typedef struct packed {
    logic  write;
    word_t addr;
    word_t wdata;
  } bus_req_t;

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_DECODE,
    ST_EXECUTE,
    ST_MEMORY,
    ST_WRITEBACK,
    ST_HALTED
  } core_state_e;

endpackage
